/* sdram_pkg.sv */
package sdram_pkg;

    // bus widths
    localparam int dw  = 16;    // data bits
    localparam int rw  = 13;    // row bits, same as the address pins
    localparam int cw  = 9;     // column bits
    localparam int baw = 2;     // bank address bits

    // commands as {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] cmd_load_mode = 4'b0000;
    localparam logic [3:0] cmd_refresh   = 4'b0001;
    localparam logic [3:0] cmd_precharge = 4'b0010;
    localparam logic [3:0] cmd_active    = 4'b0011;
    localparam logic [3:0] cmd_write     = 4'b0100;
    localparam logic [3:0] cmd_read      = 4'b0101;
    localparam logic [3:0] cmd_nop       = 4'b0111;
    localparam logic [3:0] cmd_inhibit   = 4'b1000;    // chip not selected

    // timing, all in clock cycles
    localparam int t_rcd     = 2;   // activate to read/write
    localparam int cas_lat   = 2;
    localparam int t_rp      = 2;   // precharge period
    localparam int t_rfc     = 7;   // refresh cycle
    localparam int t_wr      = 2;   // write recovery
    localparam int burst_len = 4;   // words per read

    // power-up wait
    // far below the real 100us so simulation stays short
    localparam int init_wait = 20;

endpackage

/* sdram_init.sv */
`timescale 1ns/1ns

module sdram_init (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     init,
    output logic [3:0]               cmd,
    output logic [sdram_pkg::rw-1:0] sdram_a
);

    localparam int prech_at = sdram_pkg::init_wait;
    localparam int rfsh0_at = prech_at + sdram_pkg::t_rp;
    localparam int rfsh1_at = rfsh0_at + sdram_pkg::t_rfc;
    localparam int mode_at  = rfsh1_at + sdram_pkg::t_rfc;
    localparam int done_at  = mode_at + 2;     // mode register set time
    localparam int cnt_w    = $clog2(done_at + 2);

    // single-word writes, cas latency, sequential burst of 4
    localparam logic [sdram_pkg::rw-1:0] mode_word = {
        3'b000, 1'b1, 2'b00, 3'(sdram_pkg::cas_lat), 1'b0, 3'($clog2(sdram_pkg::burst_len))
    };

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            init <= 1'b1;
        end else if (init) begin
            cnt <= cnt + 1'b1;
            if (cnt == cnt_w'(done_at))
                init <= 1'b0;
        end
    end

    always_comb begin
        cmd     = sdram_pkg::cmd_nop;
        sdram_a = '0;
        if (cnt < cnt_w'(prech_at)) begin
            cmd = sdram_pkg::cmd_inhibit;   // power-up wait
        end else if (cnt == cnt_w'(prech_at)) begin
            cmd         = sdram_pkg::cmd_precharge;
            sdram_a[10] = 1'b1;             // all banks
        end else if (cnt == cnt_w'(rfsh0_at) || cnt == cnt_w'(rfsh1_at)) begin
            cmd = sdram_pkg::cmd_refresh;
        end else if (cnt == cnt_w'(mode_at)) begin
            cmd     = sdram_pkg::cmd_load_mode;
            sdram_a = mode_word;
        end
    end

endmodule

/* sdram_rfsh.sv */
`timescale 1ns/1ns

module sdram_rfsh #(
    parameter int rfshcnt = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     bg,
    output logic                     br,
    output logic                     rfshing,
    output logic [3:0]               cmd,
    output logic [sdram_pkg::rw-1:0] sdram_a
);

    localparam int pend_w = $clog2(rfshcnt + 1) + 2;    // room for pulses stacking up
    localparam int tmr_w  = $clog2(sdram_pkg::t_rfc + sdram_pkg::t_rp + sdram_pkg::t_wr);

    logic [pend_w-1:0] pend;
    logic [tmr_w-1:0]  tmr;
    logic              fire;

    assign fire    = rfshing && tmr == '0 && pend != '0;
    assign br      = pend != '0 && !rfshing;
    assign cmd     = fire ? sdram_pkg::cmd_refresh : sdram_pkg::cmd_nop;
    assign sdram_a = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend    <= '0;
            tmr     <= '0;
            rfshing <= 1'b0;
        end else begin
            pend <= pend + (start ? pend_w'(rfshcnt) : pend_w'(0)) - pend_w'(fire);
            if (bg) begin
                rfshing <= 1'b1;
                // a row closed by a last write may still be precharging
                tmr     <= tmr_w'(sdram_pkg::t_wr + sdram_pkg::t_rp);
            end else if (rfshing) begin
                if (tmr != '0)
                    tmr <= tmr - 1'b1;
                else if (fire)
                    tmr <= tmr_w'(sdram_pkg::t_rfc - 1);
                else
                    rfshing <= 1'b0;    // last t_rfc has run out
            end
        end
    end

    // refresh only once the bus has been held through write recovery and precharge
    a_rfsh_owner: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_pkg::cmd_refresh |-> $past(rfshing, sdram_pkg::t_wr + sdram_pkg::t_rp));

endmodule

/* sdram_bank.sv */
`timescale 1ns/1ns

module sdram_bank #(
    parameter int aw = 22
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [aw-1:0]            addr,
    input  logic                     rd,
    input  logic                     wr,
    input  logic                     bg,
    input  logic                     all_dbusy,
    input  logic                     all_act,
    output logic                     ack,
    output logic                     dst,
    output logic                     dok,
    output logic                     rdy,
    output logic                     dbusy,
    output logic                     post_act,
    output logic                     br,
    output logic [3:0]               cmd,
    output logic [sdram_pkg::rw-1:0] sdram_a
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_trcd = 2'd1;
    localparam logic [1:0] st_rw   = 2'd2;
    localparam logic [1:0] st_busy = 2'd3;     // data phase and precharge recovery

    localparam int sr_len = sdram_pkg::cas_lat + sdram_pkg::burst_len;
    localparam int al_w   = $clog2(sdram_pkg::burst_len);

    logic [1:0]               state;
    logic [2:0]               cnt;
    logic                     is_wr;
    logic [sdram_pkg::cw-1:0] col;
    logic [sdram_pkg::cw-1:0] col_sel;
    logic [sdram_pkg::rw-1:0] row;
    logic [sr_len-1:0]        rd_sr;   // one bit per cycle since the read command
    logic                     act_go;
    logic                     rd_go;
    logic                     wr_go;

    assign row     = addr[aw-1:sdram_pkg::cw];
    assign col_sel = is_wr ? col : {col[sdram_pkg::cw-1:al_w], {al_w{1'b0}}};

    assign act_go = bg && state == st_idle;
    assign rd_go  = bg && state == st_rw && !is_wr;
    assign wr_go  = bg && state == st_rw && is_wr;

    always_comb begin
        case (state)
            st_idle: br = (rd || wr) && !all_act;  // one bank between act and rd/wr
            st_rw:   br = !all_dbusy;              // no other burst left on dq
            default: br = 1'b0;
        endcase
    end

    always_comb begin
        cmd = sdram_pkg::cmd_nop;
        if (act_go)
            cmd = sdram_pkg::cmd_active;
        else if (rd_go)
            cmd = sdram_pkg::cmd_read;
        else if (wr_go)
            cmd = sdram_pkg::cmd_write;
    end

    // a10 set on the column command gives auto-precharge
    assign sdram_a = state == st_idle ? row : {2'b00, 1'b1, 1'b0, col_sel};

    assign ack      = act_go;
    assign post_act = state == st_trcd || state == st_rw;
    assign dbusy    = |rd_sr;
    assign dst      = rd_sr[sdram_pkg::cas_lat] | wr_go;
    assign dok      = |rd_sr[sr_len-1:sdram_pkg::cas_lat] | wr_go;
    assign rdy      = rd_sr[sr_len-1] | wr_go;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
            is_wr <= 1'b0;
            rd_sr <= '0;
        end else begin
            rd_sr <= {rd_sr[sr_len-2:0], rd_go};
            case (state)
                st_idle: if (act_go) begin
                    state <= st_trcd;
                    is_wr <= wr;
                    cnt   <= 3'(sdram_pkg::t_rcd - 2);
                end
                st_trcd: if (cnt == '0) state <= st_rw;
                    else cnt <= cnt - 1'b1;
                st_rw: if (rd_go || wr_go) begin
                    state <= st_busy;
                    cnt   <= wr_go ? 3'(sdram_pkg::t_wr + sdram_pkg::t_rp - 1)
                                   : 3'(sdram_pkg::burst_len + sdram_pkg::t_rp - 1);
                end
                default: if (cnt == '0) state <= st_idle;
                    else cnt <= cnt - 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (act_go)
            col <= addr[sdram_pkg::cw-1:0];
    end

    // column command never lands on another bank's burst
    a_no_dq_clash: assert property (@(posedge clk) disable iff (rst)
        (rd_go || wr_go) |-> !all_dbusy);
    a_one_op: assert property (@(posedge clk) disable iff (rst) ack |-> !(rd && wr));

endmodule

/* sdram_arb.sv */
`timescale 1ns/1ns

module sdram_arb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [3:0]                br,
    input  logic                      init,
    input  logic                      rfshing,
    input  logic                      rfsh_br,
    input  logic [3:0]                init_cmd,
    input  logic [sdram_pkg::rw-1:0]  init_a,
    input  logic [3:0]                rfsh_cmd,
    input  logic [sdram_pkg::rw-1:0]  rfsh_a,
    input  logic [3:0]                bank_cmd [4],
    input  logic [sdram_pkg::rw-1:0]  bank_a [4],
    input  logic [3:0]                dbusy,
    input  logic [3:0]                post_act,
    output logic [3:0]                bg,
    output logic                      rfsh_bg,
    output logic [3:0]                next_cmd,
    output logic [sdram_pkg::rw-1:0]  next_a,
    output logic [sdram_pkg::baw-1:0] next_ba,
    output logic                      all_dbusy,
    output logic                      all_act
);

    logic [14:0] lfsr;
    logic [1:0]  prio;
    logic [1:0]  idx;
    logic [1:0]  pick;
    logic        hit;

    assign prio      = lfsr[1:0];
    assign all_dbusy = |dbusy;
    assign all_act   = |post_act;
    assign rfsh_bg   = rfsh_br && br == 4'd0 && !all_dbusy && !all_act && !init;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            lfsr <= 15'd1;
        else
            lfsr <= {lfsr[13:0], lfsr[14] ^ lfsr[13]};
    end

    // walk backwards so the closest requester at or after prio wins
    always_comb begin
        pick = prio;
        hit  = 1'b0;
        idx  = prio;
        for (int k = 3; k >= 0; k--) begin
            idx = prio + 2'(k);
            if (br[idx]) begin
                pick = idx;
                hit  = 1'b1;
            end
        end
        bg = 4'd0;
        if (hit && !init && !rfshing)
            bg[pick] = 1'b1;
    end

    always_comb begin
        next_cmd = sdram_pkg::cmd_nop;
        next_a   = '0;
        next_ba  = '0;
        if (init) begin
            next_cmd = init_cmd;
            next_a   = init_a;
        end else if (rfshing) begin
            next_cmd = rfsh_cmd;
            next_a   = rfsh_a;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bg[i]) begin
                    next_cmd = bank_cmd[i];
                    next_a   = bank_a[i];
                    next_ba  = i[sdram_pkg::baw-1:0];
                end
            end
        end
    end

    // one bank between act and rd/wr, one burst on dq
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dbusy) && $onehot0(post_act));

endmodule

/* sdram_ctrl.sv */
`timescale 1ns/1ns

module sdram_ctrl #(
    parameter int aw      = 22,
    parameter int rfshcnt = 4      // refresh commands per rfsh pulse
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      init,
    input  logic [aw-1:0]             ba0_addr,
    input  logic [aw-1:0]             ba1_addr,
    input  logic [aw-1:0]             ba2_addr,
    input  logic [aw-1:0]             ba3_addr,
    input  logic [3:0]                rd,
    input  logic [3:0]                wr,
    input  logic [sdram_pkg::dw-1:0]  din,
    input  logic [1:0]                din_m,     // high masks the byte
    input  logic                      rfsh,
    output logic [3:0]                ack,
    output logic [3:0]                dst,
    output logic [3:0]                dok,
    output logic [3:0]                rdy,
    output logic [sdram_pkg::dw-1:0]  dout,
    inout  wire  [sdram_pkg::dw-1:0]  sdram_dq,
    output logic [sdram_pkg::rw-1:0]  sdram_a,
    output logic [sdram_pkg::baw-1:0] sdram_ba,
    output logic                      sdram_dqml,
    output logic                      sdram_dqmh,
    output logic                      sdram_nwe,
    output logic                      sdram_ncas,
    output logic                      sdram_nras,
    output logic                      sdram_ncs,
    output logic                      sdram_cke
);

    logic [aw-1:0]             ba_addr [4];
    logic [3:0]                bank_cmd [4];
    logic [sdram_pkg::rw-1:0]  bank_a [4];
    logic [3:0]                br, bg, dbusy, post_act;
    logic [3:0]                ba_ack, ba_dst, ba_dok, ba_rdy;
    logic                      all_dbusy, all_act, rfsh_br, rfsh_bg, rfshing;
    logic [3:0]                init_cmd, rfsh_cmd, next_cmd, cmd;
    logic [sdram_pkg::rw-1:0]  init_a, rfsh_a, next_a;
    logic [sdram_pkg::baw-1:0] next_ba;
    logic [sdram_pkg::dw-1:0]  dq_out;
    logic                      dq_oe;
    logic [1:0]                dqm;

    assign ba_addr[0] = ba0_addr;
    assign ba_addr[1] = ba1_addr;
    assign ba_addr[2] = ba2_addr;
    assign ba_addr[3] = ba3_addr;

    assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
    assign {sdram_dqmh, sdram_dqml} = dqm;
    assign sdram_cke = 1'b1;
    assign sdram_dq  = dq_oe ? dq_out : 'z;   // driven only with a write on the pins

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd   <= sdram_pkg::cmd_inhibit;
            dqm   <= 2'b00;
            dq_oe <= 1'b0;
            {ack, dst, dok, rdy} <= '0;
            dout  <= '0;
        end else begin
            cmd   <= next_cmd;
            dq_oe <= next_cmd == sdram_pkg::cmd_write;
            dqm   <= next_cmd == sdram_pkg::cmd_write ? din_m : 2'b00;
            ack   <= ba_ack;
            dst   <= ba_dst;
            dok   <= ba_dok;
            rdy   <= ba_rdy;
            dout  <= sdram_dq;     // lines up with the registered dok
        end
    end

    always_ff @(posedge clk) begin
        sdram_a  <= next_a;
        sdram_ba <= next_ba;
        dq_out   <= din;
    end

    sdram_init u_init (
        .clk(clk), .rst(rst), .init(init), .cmd(init_cmd), .sdram_a(init_a)
    );

    sdram_rfsh #(.rfshcnt(rfshcnt)) u_rfsh (
        .clk(clk), .rst(rst), .start(rfsh), .bg(rfsh_bg),
        .br(rfsh_br), .rfshing(rfshing), .cmd(rfsh_cmd), .sdram_a(rfsh_a)
    );

    for (genvar i = 0; i < 4; i++) begin : g_bank
        sdram_bank #(.aw(aw)) u_bank (
            .clk(clk), .rst(rst), .addr(ba_addr[i]), .rd(rd[i]), .wr(wr[i]),
            .bg(bg[i]), .all_dbusy(all_dbusy), .all_act(all_act),
            .ack(ba_ack[i]), .dst(ba_dst[i]), .dok(ba_dok[i]), .rdy(ba_rdy[i]),
            .dbusy(dbusy[i]), .post_act(post_act[i]), .br(br[i]),
            .cmd(bank_cmd[i]), .sdram_a(bank_a[i])
        );
    end

    sdram_arb u_arb (
        .clk(clk), .rst(rst), .br(br), .init(init), .rfshing(rfshing),
        .rfsh_br(rfsh_br), .init_cmd(init_cmd), .init_a(init_a),
        .rfsh_cmd(rfsh_cmd), .rfsh_a(rfsh_a), .bank_cmd(bank_cmd), .bank_a(bank_a),
        .dbusy(dbusy), .post_act(post_act), .bg(bg), .rfsh_bg(rfsh_bg),
        .next_cmd(next_cmd), .next_a(next_a), .next_ba(next_ba),
        .all_dbusy(all_dbusy), .all_act(all_act)
    );

endmodule

/* tb_sdram_model.sv */
`timescale 1ns/1ns

module tb_sdram_model (
    input  logic                      clk,
    inout  wire  [sdram_pkg::dw-1:0]  dq,
    input  logic [sdram_pkg::rw-1:0]  a,
    input  logic [sdram_pkg::baw-1:0] ba,
    input  logic                      dqml,
    input  logic                      dqmh,
    input  logic                      nwe,
    input  logic                      ncas,
    input  logic                      nras,
    input  logic                      ncs,
    input  logic                      cke
);

    localparam int depth = sdram_pkg::cas_lat + sdram_pkg::burst_len;

    logic [15:0]             mem [int];     // sparse, key is {ba, row, col}
    logic [sdram_pkg::rw-1:0] open_row [4];
    logic [15:0]             pipe_d [depth];
    logic                    pipe_v [depth];
    logic [15:0]             dq_drv;
    logic                    dq_en;
    logic [3:0]              cmd;
    int                      rfsh_since_act;    // refresh commands since the last activate

    assign cmd = {ncs, nras, ncas, nwe};
    assign dq  = dq_en ? dq_drv : 'z;

    // unwritten words follow the whole address
    function automatic logic [15:0] fetch(input int key);
        if (mem.exists(key))
            return mem[key];
        return key[15:0] ^ {8'h00, key[23:16]};
    endfunction

    initial begin
        dq_en          = 1'b0;
        dq_drv         = '0;
        rfsh_since_act = 0;
        for (int i = 0; i < depth; i++) begin
            pipe_v[i] = 1'b0;
            pipe_d[i] = '0;
        end
    end

    always @(posedge clk) begin
        int          key;
        logic [15:0] old;
        for (int i = 0; i < depth - 1; i++) begin
            pipe_v[i] = pipe_v[i+1];
            pipe_d[i] = pipe_d[i+1];
        end
        pipe_v[depth-1] = 1'b0;
        if (cke) begin
            case (cmd)
                sdram_pkg::cmd_active: begin
                    open_row[ba]   = a;
                    rfsh_since_act = 0;
                end
                sdram_pkg::cmd_refresh: begin
                    rfsh_since_act = rfsh_since_act + 1;
                end
                sdram_pkg::cmd_write: begin
                    key      = {8'h00, ba, open_row[ba], a[8:0]};
                    old      = fetch(key);
                    mem[key] = {dqmh ? old[15:8] : dq[15:8], dqml ? old[7:0] : dq[7:0]};
                end
                sdram_pkg::cmd_read: begin
                    for (int k = 0; k < sdram_pkg::burst_len; k++) begin
                        key = {8'h00, ba, open_row[ba], a[8:2], 2'(a[1:0] + k)};
                        pipe_v[sdram_pkg::cas_lat-1+k] = 1'b1;
                        pipe_d[sdram_pkg::cas_lat-1+k] = fetch(key);
                    end
                end
                default: ;
            endcase
        end
        dq_en  <= #1 pipe_v[0];    // word stays up through the next edge
        dq_drv <= #1 pipe_d[0];
    end

endmodule

/* tb_sdram.sv */
`timescale 1ns/1ns

module tb_sdram;

    localparam int aw         = 22;
    localparam int rfshcnt    = 4;
    localparam int init_cycles = sdram_pkg::init_wait + sdram_pkg::t_rp
                                 + 2 * sdram_pkg::t_rfc + 3;

    logic clk, rst, rfsh, init;
    logic [aw-1:0] ba0_addr, ba1_addr, ba2_addr, ba3_addr;
    logic [3:0]  rd, wr, ack, dst, dok, rdy;
    logic [15:0] din, dout;
    logic [1:0]  din_m;
    wire  [15:0] sdram_dq;
    logic [12:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic sdram_dqml, sdram_dqmh, sdram_nwe, sdram_ncas, sdram_nras, sdram_ncs, sdram_cke;

    // golden operations
    byte         op_c [64];
    int          op_b [64];
    logic [21:0] op_a [64];
    logic [15:0] op_d [64];
    logic [1:0]  op_m [64];
    logic [15:0] op_e [64][4];
    int          n_ops;
    bit          loaded;

    logic [aw-1:0] addr_v [4];
    logic [15:0]   exp_v [4][4];
    int            errors;
    int            checks;

    sdram_ctrl #(.aw(aw), .rfshcnt(rfshcnt)) DUT (
        .clk(clk), .rst(rst), .init(init),
        .ba0_addr(ba0_addr), .ba1_addr(ba1_addr), .ba2_addr(ba2_addr), .ba3_addr(ba3_addr),
        .rd(rd), .wr(wr), .din(din), .din_m(din_m), .rfsh(rfsh),
        .ack(ack), .dst(dst), .dok(dok), .rdy(rdy), .dout(dout),
        .sdram_dq(sdram_dq), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
        .sdram_dqml(sdram_dqml), .sdram_dqmh(sdram_dqmh), .sdram_nwe(sdram_nwe),
        .sdram_ncas(sdram_ncas), .sdram_nras(sdram_nras), .sdram_ncs(sdram_ncs),
        .sdram_cke(sdram_cke)
    );

    tb_sdram_model u_model (
        .clk(clk), .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba),
        .dqml(sdram_dqml), .dqmh(sdram_dqmh), .nwe(sdram_nwe), .ncas(sdram_ncas),
        .nras(sdram_nras), .ncs(sdram_ncs), .cke(sdram_cke)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // post requests and follow every bank until its rdy
    task automatic run_access(input logic [3:0] rmask, input logic [3:0] wmask,
                              input bit check_data);
        int         cnt [4];
        logic [3:0] want;
        logic [3:0] done;
        want = rmask | wmask;
        done = '0;
        for (int b = 0; b < 4; b++)
            cnt[b] = 0;
        ba0_addr = addr_v[0];
        ba1_addr = addr_v[1];
        ba2_addr = addr_v[2];
        ba3_addr = addr_v[3];
        rd = rmask;
        wr = wmask;
        while (done != want) begin
            step(1);
            compare("dok on several banks", 32'($countones(dok) > 1), 0);
            for (int b = 0; b < 4; b++) begin
                if (ack[b]) begin
                    compare("ack without pending request", 32'(rd[b] | wr[b]), 1);
                    rd[b] = 1'b0;
                    wr[b] = 1'b0;
                end
                if (dok[b]) begin
                    compare("dok on a bank without request", 32'(want[b]), 1);
                    compare("dst", 32'(dst[b]), 32'(cnt[b] == 0));
                    if (rmask[b] && check_data)
                        compare($sformatf("bank %0d word %0d", b, cnt[b]), 32'(dout),
                                32'(exp_v[b][cnt[b] % 4]));
                    cnt[b] = cnt[b] + 1;
                    if (rdy[b]) begin
                        done[b] = 1'b1;
                        compare("dok cycles", cnt[b], rmask[b] ? 4 : 1);
                    end
                end else begin
                    compare("rdy without dok", 32'(rdy[b]), 0);
                    compare("dst without dok", 32'(dst[b]), 0);
                end
            end
        end
    endtask

    task automatic refresh_pulse();
        rfsh = 1'b1;
        step(1);
        rfsh = 1'b0;
        while (u_model.rfsh_since_act < rfshcnt)
            step(1);
        step(3 * sdram_pkg::t_rfc);    // room for any extra refresh to show up
        compare("refreshes before next activate", u_model.rfsh_since_act, rfshcnt);
    endtask

    task automatic load_golden();
        int    fd;
        int    b;
        string line;
        logic [31:0] a, d, m, e0, e1, e2, e3;
        byte   c;
        n_ops = 0;
        fd = $fopen("sdram_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open sdram_golden.txt for reading");
            errors = errors + 1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            if ($sscanf(line, "%c %h %h %h %h %h %h %h %h", c, b, a, d, m, e0, e1, e2, e3)
                    == 9 && n_ops < 64) begin
                op_c[n_ops] = c;
                op_b[n_ops] = b;
                op_a[n_ops] = a[21:0];
                op_d[n_ops] = d[15:0];
                op_m[n_ops] = m[1:0];
                op_e[n_ops] = '{e0[15:0], e1[15:0], e2[15:0], e3[15:0]};
                n_ops = n_ops + 1;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int n;
        void'($urandom(32'h4b45650f));
        errors = 0;
        checks = 0;
        loaded = 1'b0;
        rst = 1'b1;
        rfsh = 1'b0;
        rd = '0;
        wr = '0;
        din = '0;
        din_m = '0;
        ba0_addr = '0;
        ba1_addr = '0;
        ba2_addr = '0;
        ba3_addr = '0;
        for (int b = 0; b < 4; b++)
            addr_v[b] = '0;
        load_golden();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #10 rst = 1'b0;

        // a read waits through the whole power-up sequence
        compare("init after reset", 32'(init), 1);
        compare("outputs after reset", {ack, dst, dok, rdy, dout}, 0);
        rd[0] = 1'b1;
        n = 0;
        while (init) begin
            compare("ack during init", 32'(ack), 0);
            step(1);
            n = n + 1;
        end
        compare("init cycles", n, init_cycles);
        run_access(4'b0001, 4'b0000, 1'b0);

        for (int i = 0; i < n_ops; i++) begin
            addr_v[op_b[i]] = op_a[i];
            exp_v[op_b[i]]  = op_e[i];
            case (op_c[i])
                "W": begin
                    din   = op_d[i];
                    din_m = op_m[i];
                    run_access(4'b0000, 4'(1 << op_b[i]), 1'b0);
                end
                "R": run_access(4'(1 << op_b[i]), 4'b0000, 1'b1);
                "P": if (op_b[i] == 3) run_access(4'b1111, 4'b0000, 1'b1);
                "F": refresh_pulse();
                default: compare("golden operation code", 32'(op_c[i]), 32'("W"));
            endcase
            step($urandom % 4);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (n_ops + init_cycles) * 60;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped answering", limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* sdram_golden.txt */
# op bank addr data mask exp0 exp1 exp2 exp3, all hex; a mask bit set keeps that byte
# W write, R read, F refresh pulse, P parallel read that starts on its bank 3 line
W 0 000100 1111 0 0 0 0 0
W 0 000101 2222 0 0 0 0 0
W 0 000102 3333 0 0 0 0 0
W 0 000103 4444 0 0 0 0 0
R 0 000101 0 0 1111 2222 3333 4444
W 0 000102 ab55 1 0 0 0 0
R 0 000100 0 0 1111 2222 ab33 4444
W 1 000a20 5000 0 0 0 0 0
W 1 000a21 5001 0 0 0 0 0
W 1 000a22 5002 0 0 0 0 0
W 1 000a23 5003 0 0 0 0 0
W 2 3ffe04 c0de 0 0 0 0 0
W 2 3ffe05 c0df 0 0 0 0 0
W 2 3ffe06 c0e0 0 0 0 0 0
W 2 3ffe07 c0e1 0 0 0 0 0
W 3 000460 9a00 0 0 0 0 0
W 3 000461 9a01 0 0 0 0 0
W 3 000462 9a02 0 0 0 0 0
W 3 000463 9a03 0 0 0 0 0
F 0 000000 0 0 0 0 0 0
P 0 000100 0 0 1111 2222 ab33 4444
P 1 000a22 0 0 5000 5001 5002 5003
P 2 3ffe04 0 0 c0de c0df c0e0 c0e1
P 3 000461 0 0 9a00 9a01 9a02 9a03
W 3 000462 0077 2 0 0 0 0
R 3 000460 0 0 9a00 9a01 9a77 9a03

/* all.f */
sdram_pkg.sv
sdram_init.sv
sdram_rfsh.sv
sdram_bank.sv
sdram_arb.sv
sdram_ctrl.sv
tb_sdram_model.sv
tb_sdram.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram -f all.f -o sim_sdram
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_sdram > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
